// ==== include/solver_defs.svh ====
`ifndef SOLVER_DEFS_SVH
`define SOLVER_DEFS_SVH

// Operand width as entered by the operator
`define SOLVER_IN_W 8

// One guard bit over the operand width
`define SOLVER_DATA_W 9

// Six operands, three determinants and two partial products
`define SOLVER_NUM_REGS 11

`define SOLVER_ADDR_W 4

// Length of the compute program
`define SOLVER_CALC_STEPS 11

`endif

// ==== hdl/solver_data_pkg.sv ====
`default_nettype none

`include "solver_defs.svh"

package solver_data_pkg;

    typedef logic [`SOLVER_IN_W-1:0]          in_word_t;   // Raw operand
    typedef logic signed [`SOLVER_DATA_W-1:0] data_word_t; // Working value
    typedef logic [`SOLVER_ADDR_W-1:0]        reg_addr_t;

    // Working register map
    localparam reg_addr_t R_A1  = 4'd0;
    localparam reg_addr_t R_A2  = 4'd1;
    localparam reg_addr_t R_B1  = 4'd2;
    localparam reg_addr_t R_B2  = 4'd3;
    localparam reg_addr_t R_C1  = 4'd4;
    localparam reg_addr_t R_C2  = 4'd5;
    localparam reg_addr_t R_DET = 4'd6;
    localparam reg_addr_t R_DX  = 4'd7;
    localparam reg_addr_t R_DY  = 4'd8;
    localparam reg_addr_t R_P1  = 4'd9;
    localparam reg_addr_t R_P2  = 4'd10;

endpackage

`default_nettype wire

// ==== hdl/solver_ctrl_pkg.sv ====
`default_nettype none

package solver_ctrl_pkg;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,
        OP_MUL = 2'b01,
        OP_SUB = 2'b10,
        OP_DIV = 2'b11
    } alu_op_t;

    // Each operand has a load state and a wait state for go to drop
    typedef enum logic [4:0] {
        LOAD_A1,
        LOAD_A1_WAIT,
        LOAD_A2,
        LOAD_A2_WAIT,
        LOAD_B1,
        LOAD_B1_WAIT,
        LOAD_B2,
        LOAD_B2_WAIT,
        LOAD_C1,
        LOAD_C1_WAIT,
        LOAD_C2,
        LOAD_C2_WAIT,
        CALC_0,
        CALC_1,
        CALC_2,
        CALC_3,
        CALC_4,
        CALC_5,
        CALC_6,
        CALC_7,
        CALC_8,
        CALC_9,
        CALC_10
    } solver_state_t;

endpackage

`default_nettype wire

// ==== hdl/solver_alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module solver_alu (
    input  solver_data_pkg::data_word_t opnd_a,
    input  solver_data_pkg::data_word_t opnd_b,
    input  solver_ctrl_pkg::alu_op_t    alu_op,
    output solver_data_pkg::data_word_t alu_result
);
    import solver_ctrl_pkg::*;

    // All results wrap to the working width
    always_comb begin
        case (alu_op)
            OP_ADD: alu_result = opnd_a + opnd_b;
            OP_SUB: alu_result = opnd_a - opnd_b;
            OP_MUL: alu_result = opnd_a * opnd_b; // Low bits of the product
            OP_DIV: begin
                if (opnd_b == '0)
                    alu_result = '0;
                else
                    alu_result = opnd_a / opnd_b; // Truncates toward zero
            end
            default: alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/solver_regfile.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "solver_defs.svh"

module solver_regfile (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         wr_en,
    input  wire                         wr_from_alu,
    input  solver_data_pkg::reg_addr_t  wr_addr,
    input  solver_data_pkg::reg_addr_t  rd_addr_a,
    input  solver_data_pkg::reg_addr_t  rd_addr_b,
    input  solver_data_pkg::in_word_t   data_in,
    input  solver_data_pkg::data_word_t alu_result,
    output solver_data_pkg::data_word_t opnd_a,
    output solver_data_pkg::data_word_t opnd_b
);
    import solver_data_pkg::*;

    localparam int EXT_W = `SOLVER_DATA_W - `SOLVER_IN_W;

    data_word_t regs [`SOLVER_NUM_REGS];
    data_word_t data_in_ext;
    data_word_t wr_data;

    // Operands are signed on entry
    assign data_in_ext = {{EXT_W{data_in[`SOLVER_IN_W-1]}}, data_in};
    assign wr_data     = wr_from_alu ? alu_result : data_in_ext;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `SOLVER_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en && (wr_addr < `SOLVER_NUM_REGS)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Unmapped addresses read as zero
    always_comb begin
        if (rd_addr_a < `SOLVER_NUM_REGS)
            opnd_a = regs[rd_addr_a];
        else
            opnd_a = '0;

        if (rd_addr_b < `SOLVER_NUM_REGS)
            opnd_b = regs[rd_addr_b];
        else
            opnd_b = '0;
    end

endmodule

`default_nettype wire

// ==== hdl/solver_control.sv ====
`default_nettype none
`timescale 1ns/100ps

module solver_control (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        go,
    output logic                       wr_en,
    output logic                       wr_from_alu,
    output solver_data_pkg::reg_addr_t wr_addr,
    output solver_data_pkg::reg_addr_t rd_addr_a,
    output solver_data_pkg::reg_addr_t rd_addr_b,
    output solver_ctrl_pkg::alu_op_t   alu_op,
    output logic                       calc_start,
    output logic                       det_load,
    output logic                       dy_load,
    output logic                       dx_load,
    output logic                       x_load,
    output logic                       y_load
);
    import solver_data_pkg::*;
    import solver_ctrl_pkg::*;

    solver_state_t state;
    solver_state_t state_next;

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= LOAD_A1;
        else
            state <= state_next;
    end

    always_comb begin
        case (state)
            LOAD_A1:      state_next = go ? LOAD_A1_WAIT : LOAD_A1;
            LOAD_A1_WAIT: state_next = go ? LOAD_A1_WAIT : LOAD_A2;
            LOAD_A2:      state_next = go ? LOAD_A2_WAIT : LOAD_A2;
            LOAD_A2_WAIT: state_next = go ? LOAD_A2_WAIT : LOAD_B1;
            LOAD_B1:      state_next = go ? LOAD_B1_WAIT : LOAD_B1;
            LOAD_B1_WAIT: state_next = go ? LOAD_B1_WAIT : LOAD_B2;
            LOAD_B2:      state_next = go ? LOAD_B2_WAIT : LOAD_B2;
            LOAD_B2_WAIT: state_next = go ? LOAD_B2_WAIT : LOAD_C1;
            LOAD_C1:      state_next = go ? LOAD_C1_WAIT : LOAD_C1;
            LOAD_C1_WAIT: state_next = go ? LOAD_C1_WAIT : LOAD_C2;
            LOAD_C2:      state_next = go ? LOAD_C2_WAIT : LOAD_C2;
            LOAD_C2_WAIT: state_next = go ? LOAD_C2_WAIT : CALC_0;
            CALC_0:       state_next = CALC_1; // go is ignored from here on
            CALC_1:       state_next = CALC_2;
            CALC_2:       state_next = CALC_3;
            CALC_3:       state_next = CALC_4;
            CALC_4:       state_next = CALC_5;
            CALC_5:       state_next = CALC_6;
            CALC_6:       state_next = CALC_7;
            CALC_7:       state_next = CALC_8;
            CALC_8:       state_next = CALC_9;
            CALC_9:       state_next = CALC_10;
            default:      state_next = LOAD_A1;
        endcase
    end

    // Register write side
    always_comb begin
        wr_en       = 1'b1;
        wr_from_alu = 1'b1;
        wr_addr     = R_A1;
        case (state)
            LOAD_A1: begin
                wr_from_alu = 1'b0;
                wr_addr     = R_A1;
            end
            LOAD_A2: begin
                wr_from_alu = 1'b0;
                wr_addr     = R_A2;
            end
            LOAD_B1: begin
                wr_from_alu = 1'b0;
                wr_addr     = R_B1;
            end
            LOAD_B2: begin
                wr_from_alu = 1'b0;
                wr_addr     = R_B2;
            end
            LOAD_C1: begin
                wr_from_alu = 1'b0;
                wr_addr     = R_C1;
            end
            LOAD_C2: begin
                wr_from_alu = 1'b0;
                wr_addr     = R_C2;
            end
            CALC_0:  wr_addr = R_P1; // a1*b2
            CALC_1:  wr_addr = R_P2; // b1*a2
            CALC_2:  wr_addr = R_B2; // c1*b2 overwrites b2
            CALC_3:  wr_addr = R_B1; // b1*c2 overwrites b1
            CALC_4:  wr_addr = R_A1; // a1*c2 overwrites a1
            CALC_5:  wr_addr = R_A2; // c1*a2 overwrites a2
            CALC_6:  wr_addr = R_DET;
            CALC_7:  wr_addr = R_DY;
            CALC_8:  wr_addr = R_DX;
            default: begin
                wr_en       = 1'b0; // Wait states and the two divisions
                wr_from_alu = 1'b0;
            end
        endcase
    end

    // ALU operand selection and opcode
    always_comb begin
        rd_addr_a = R_A1;
        rd_addr_b = R_A1;
        alu_op    = OP_MUL;
        case (state)
            CALC_0: begin
                rd_addr_a = R_A1;
                rd_addr_b = R_B2;
            end
            CALC_1: begin
                rd_addr_a = R_B1;
                rd_addr_b = R_A2;
            end
            CALC_2: begin
                rd_addr_a = R_C1;
                rd_addr_b = R_B2;
            end
            CALC_3: begin
                rd_addr_a = R_B1;
                rd_addr_b = R_C2;
            end
            CALC_4: begin
                rd_addr_a = R_A1;
                rd_addr_b = R_C2;
            end
            CALC_5: begin
                rd_addr_a = R_C1;
                rd_addr_b = R_A2;
            end
            CALC_6: begin
                rd_addr_a = R_P1;
                rd_addr_b = R_P2;
                alu_op    = OP_SUB;
            end
            CALC_7: begin
                rd_addr_a = R_A1; // a1*c2 - c1*a2
                rd_addr_b = R_A2;
                alu_op    = OP_SUB;
            end
            CALC_8: begin
                rd_addr_a = R_B2; // c1*b2 - b1*c2
                rd_addr_b = R_B1;
                alu_op    = OP_SUB;
            end
            CALC_9: begin
                rd_addr_a = R_DX;
                rd_addr_b = R_DET;
                alu_op    = OP_DIV;
            end
            CALC_10: begin
                rd_addr_a = R_DY;
                rd_addr_b = R_DET;
                alu_op    = OP_DIV;
            end
            default: alu_op = OP_ADD;
        endcase
    end

    assign calc_start = (state == CALC_0);
    assign det_load   = (state == CALC_6);
    assign dy_load    = (state == CALC_7);
    assign dx_load    = (state == CALC_8);
    assign x_load     = (state == CALC_9);
    assign y_load     = (state == CALC_10);

endmodule

`default_nettype wire

// ==== hdl/solver_result.sv ====
`default_nettype none
`timescale 1ns/100ps

module solver_result (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         calc_start,
    input  wire                         det_load,
    input  wire                         dy_load,
    input  wire                         dx_load,
    input  wire                         x_load,
    input  wire                         y_load,
    input  solver_data_pkg::data_word_t alu_result,
    output solver_data_pkg::data_word_t x,
    output solver_data_pkg::data_word_t y,
    output logic                        infinite,
    output logic                        no_solution
);
    logic result_zero;
    logic det_zero;
    logic dy_zero;
    logic dx_zero;

    assign result_zero = ~|alu_result;

    // Zero tags for the three determinants
    always_ff @(posedge clk) begin
        if (!resetn) begin
            det_zero <= 1'b0;
            dy_zero  <= 1'b0;
            dx_zero  <= 1'b0;
        end else begin
            if (det_load)
                det_zero <= result_zero;
            if (dy_load)
                dy_zero <= result_zero;
            if (dx_load)
                dx_zero <= result_zero;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            x           <= '0;
            y           <= '0;
            infinite    <= 1'b0;
            no_solution <= 1'b0;
        end else begin
            if (calc_start) begin
                infinite    <= 1'b0;
                no_solution <= 1'b0;
            end
            if (x_load)
                x <= det_zero ? '0 : alu_result;
            if (y_load) begin
                y <= det_zero ? '0 : alu_result;
                // All three determinants zero means the lines coincide
                infinite    <= det_zero & dx_zero & dy_zero;
                no_solution <= det_zero & ~(dx_zero & dy_zero);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/linear_solver.sv ====
`default_nettype none
`timescale 1ns/100ps

module linear_solver (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         go,
    input  solver_data_pkg::in_word_t   data_in,
    output solver_data_pkg::data_word_t x,
    output solver_data_pkg::data_word_t y,
    output wire                         infinite,
    output wire                         no_solution
);
    import solver_data_pkg::*;
    import solver_ctrl_pkg::*;

    wire        wr_en;
    wire        wr_from_alu;
    reg_addr_t  wr_addr;
    reg_addr_t  rd_addr_a;
    reg_addr_t  rd_addr_b;
    alu_op_t    alu_op;
    wire        calc_start;
    wire        det_load;
    wire        dy_load;
    wire        dx_load;
    wire        x_load;
    wire        y_load;
    data_word_t opnd_a;
    data_word_t opnd_b;
    data_word_t alu_result;

    solver_control u_solver_control (
        .clk         (clk),
        .resetn      (resetn),
        .go          (go),
        .wr_en       (wr_en),
        .wr_from_alu (wr_from_alu),
        .wr_addr     (wr_addr),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .alu_op      (alu_op),
        .calc_start  (calc_start),
        .det_load    (det_load),
        .dy_load     (dy_load),
        .dx_load     (dx_load),
        .x_load      (x_load),
        .y_load      (y_load)
    );

    solver_regfile u_solver_regfile (
        .clk         (clk),
        .resetn      (resetn),
        .wr_en       (wr_en),
        .wr_from_alu (wr_from_alu),
        .wr_addr     (wr_addr),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .data_in     (data_in),
        .alu_result  (alu_result),
        .opnd_a      (opnd_a),
        .opnd_b      (opnd_b)
    );

    solver_alu u_solver_alu (
        .opnd_a     (opnd_a),
        .opnd_b     (opnd_b),
        .alu_op     (alu_op),
        .alu_result (alu_result)
    );

    solver_result u_solver_result (
        .clk         (clk),
        .resetn      (resetn),
        .calc_start  (calc_start),
        .det_load    (det_load),
        .dy_load     (dy_load),
        .dx_load     (dx_load),
        .x_load      (x_load),
        .y_load      (y_load),
        .alu_result  (alu_result),
        .x           (x),
        .y           (y),
        .infinite    (infinite),
        .no_solution (no_solution)
    );

endmodule

`default_nettype wire

// ==== sim/linear_solver_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module linear_solver_checker (
    input wire                         clk,
    input wire                         resetn,
    input solver_data_pkg::data_word_t x,
    input solver_data_pkg::data_word_t y,
    input wire                         infinite,
    input wire                         no_solution
);

    // A singular system is coincident or parallel but never both
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!resetn)
        !(infinite && no_solution))
        else $error("infinite and no_solution are high together");

    a_flag_zero_result: assert property (@(posedge clk) disable iff (!resetn)
        (infinite || no_solution) |-> (x == '0 && y == '0))
        else $error("A flag is raised while x or y is not zero");

    a_flags_clear_after_reset: assert property (@(posedge clk)
        $rose(resetn) |-> (!infinite && !no_solution))
        else $error("Flags are not clear after reset release");

endmodule

bind linear_solver linear_solver_checker u_linear_solver_checker (
    .clk         (clk),
    .resetn      (resetn),
    .x           (x),
    .y           (y),
    .infinite    (infinite),
    .no_solution (no_solution)
);

`default_nettype wire

// ==== sim/linear_solver_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "solver_defs.svh"

module linear_solver_tb;
    import solver_data_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_DIRECTED    = 5;
    localparam int NUM_RANDOM      = 20;
    localparam int NUM_CASES       = NUM_DIRECTED + NUM_RANDOM;
    localparam int WATCHDOG_CYCLES = NUM_CASES * 40 + 100;

    logic       clk = 1'b0;
    logic       resetn;
    logic       go;
    in_word_t   data_in;
    data_word_t x;
    data_word_t y;
    wire        infinite;
    wire        no_solution;

    // Operands in entry order a1, a2, b1, b2, c1, c2
    int opnd_table [NUM_CASES][6];
    int exp_x      [NUM_CASES];
    int exp_y      [NUM_CASES];
    bit exp_inf    [NUM_CASES];
    bit exp_nosol  [NUM_CASES];

    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] rng_state   = 32'hafbe;

    linear_solver u_linear_solver (
        .clk         (clk),
        .resetn      (resetn),
        .go          (go),
        .data_in     (data_in),
        .x           (x),
        .y           (y),
        .infinite    (infinite),
        .no_solution (no_solution)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Keep the low 9 bits as a signed value
    function automatic int wrap9(input int value);
        logic signed [8:0] low;
        low = value[8:0];
        return int'(low);
    endfunction

    // Cramer's rule with 9-bit wrapping at every step
    task automatic solve_reference(input int a1, input int a2, input int b1, input int b2,
                                   input int c1, input int c2, output int ex, output int ey,
                                   output bit inf, output bit nosol);
        int d;
        int dx;
        int dy;
        d  = wrap9(wrap9(a1 * b2) - wrap9(b1 * a2));
        dx = wrap9(wrap9(c1 * b2) - wrap9(b1 * c2));
        dy = wrap9(wrap9(a1 * c2) - wrap9(c1 * a2));
        if (d == 0) begin
            ex    = 0;
            ey    = 0;
            inf   = (dx == 0) && (dy == 0);
            nosol = !inf;
        end else begin
            ex    = wrap9(dx / d); // SV division truncates toward zero
            ey    = wrap9(dy / d);
            inf   = 1'b0;
            nosol = 1'b0;
        end
    endtask

    task automatic set_case(input int idx, input int a1, input int a2, input int b1,
                            input int b2, input int c1, input int c2, input int ex,
                            input int ey, input bit inf, input bit nosol);
        opnd_table[idx][0] = a1;
        opnd_table[idx][1] = a2;
        opnd_table[idx][2] = b1;
        opnd_table[idx][3] = b2;
        opnd_table[idx][4] = c1;
        opnd_table[idx][5] = c2;
        exp_x[idx]         = ex;
        exp_y[idx]         = ey;
        exp_inf[idx]       = inf;
        exp_nosol[idx]     = nosol;
    endtask

    task automatic fill_random_cases();
        int ops [6];
        int ex;
        int ey;
        bit inf;
        bit nosol;
        for (int i = NUM_DIRECTED; i < NUM_CASES; i++) begin
            for (int k = 0; k < 6; k++) begin
                rng_state = xorshift32(rng_state);
                ops[k]    = int'($signed(rng_state[7:0])); // Full signed 8-bit range
            end
            solve_reference(ops[0], ops[1], ops[2], ops[3], ops[4], ops[5],
                            ex, ey, inf, nosol);
            set_case(i, ops[0], ops[1], ops[2], ops[3], ops[4], ops[5], ex, ey, inf, nosol);
        end
    endtask

    // Value is captured on the edge that first sees go high
    task automatic enter_operand(input int value);
        data_in <= value[7:0];
        go      <= 1'b1;
        repeat (2) @(posedge clk);
        go      <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic check_flags_cleared(input int idx);
        check_count += 2;
        if (infinite !== 1'b0) begin
            error_count++;
            $display("FAILED %0t ns: case %0d infinite not cleared at compute start",
                     $time, idx);
        end
        if (no_solution !== 1'b0) begin
            error_count++;
            $display("FAILED %0t ns: case %0d no_solution not cleared at compute start",
                     $time, idx);
        end
    endtask

    task automatic check_outputs(input int idx);
        data_word_t want_x;
        data_word_t want_y;
        want_x = exp_x[idx][8:0];
        want_y = exp_y[idx][8:0];
        check_count += 4;
        if (x !== want_x) begin
            error_count++;
            $display("FAILED %0t ns: case %0d x is %0d, expected %0d", $time, idx, x, want_x);
        end
        if (y !== want_y) begin
            error_count++;
            $display("FAILED %0t ns: case %0d y is %0d, expected %0d", $time, idx, y, want_y);
        end
        if (infinite !== exp_inf[idx]) begin
            error_count++;
            $display("FAILED %0t ns: case %0d infinite is %b, expected %b",
                     $time, idx, infinite, exp_inf[idx]);
        end
        if (no_solution !== exp_nosol[idx]) begin
            error_count++;
            $display("FAILED %0t ns: case %0d no_solution is %b, expected %b",
                     $time, idx, no_solution, exp_nosol[idx]);
        end
    endtask

    task automatic run_case(input int idx);
        @(posedge clk);
        for (int k = 0; k < 6; k++)
            enter_operand(opnd_table[idx][k]);
        // Step 0 is over, the previous flags must be gone
        @(negedge clk);
        check_flags_cleared(idx);
        // Results settle a fixed time after the last program step
        repeat (`SOLVER_CALC_STEPS + 2) @(posedge clk);
        @(negedge clk);
        check_outputs(idx);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the simulation ran past its time limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        resetn  <= 1'b0;
        go      <= 1'b0;
        data_in <= '0;

        set_case(0, 2, 1, 1, 3, 5, 10, 1, 3, 1'b0, 1'b0);      // 2x+y=5, x+3y=10
        set_case(1, -3, 2, 4, 1, -10, -7, -1, -3, 1'b0, 1'b0); // Inexact, negative
        set_case(2, 1, 2, 1, 2, 2, 5, 0, 0, 1'b0, 1'b1);       // Parallel lines
        set_case(3, 1, 2, 2, 4, 3, 6, 0, 0, 1'b1, 1'b0);       // Same line twice
        set_case(4, 1, 1, -1, 1, 1, 7, 4, 3, 1'b0, 1'b0);      // Regular after singular
        fill_random_cases();

        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < NUM_CASES; i++)
            run_case(i);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hdl/solver_data_pkg.sv
hdl/solver_ctrl_pkg.sv
hdl/solver_alu.sv
hdl/solver_regfile.sv
hdl/solver_control.sv
hdl/solver_result.sv
hdl/linear_solver.sv
sim/linear_solver_checker.sv
sim/linear_solver_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module linear_solver_tb -o linear_solver_sim \
    || { echo "Verilator build failed"; exit 1; }
sim_output=$(./obj_dir/linear_solver_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "Test passed" && exit 0 || exit 1
